/* common/isaPkg.sv */
`default_nettype none

package isaPkg;

  localparam int dataWidth = 32;
  localparam int regAddrWidth = 4;
  localparam int numRegs = 16;

  // Data-processing opcodes, instruction bits 24:21
  typedef enum logic [3:0] {
    opAnd = 4'd0,
    opEor = 4'd1,
    opSub = 4'd2,
    opRsb = 4'd3,
    opAdd = 4'd4,
    opAdc = 4'd5,
    opSbc = 4'd6,
    opRsc = 4'd7,
    opTst = 4'd8,
    opTeq = 4'd9,
    opCmp = 4'd10,
    opCmn = 4'd11,
    opOrr = 4'd12,
    opMov = 4'd13,
    opBic = 4'd14,
    opMvn = 4'd15
  } opcodeT;

  // Register form, operand 2 from Rm
  typedef struct packed {
    logic [3:0] cond;
    logic [1:0] classBits;
    logic immFlag;
    opcodeT opcode;
    logic setFlags;
    logic [regAddrWidth-1:0] rn;
    logic [regAddrWidth-1:0] rd;
    logic [7:0] shift;
    logic [regAddrWidth-1:0] rm;
  } regOperandT;

  // Immediate form, operand 2 from imm8
  typedef struct packed {
    logic [3:0] cond;
    logic [1:0] classBits;
    logic immFlag;
    opcodeT opcode;
    logic setFlags;
    logic [regAddrWidth-1:0] rn;
    logic [regAddrWidth-1:0] rd;
    logic [3:0] rotate;
    logic [7:0] imm8;
  } immOperandT;

  typedef union packed {
    regOperandT regForm;
    immOperandT immForm;
  } instrT;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

endpackage

`default_nettype wire

/* common/corePkg.sv */
`default_nettype none

package corePkg;

  localparam int stateWidth = 2;
  localparam int nextSelWidth = 2;

  // Microstates
  localparam logic [stateWidth-1:0] stIdle = 2'd0;
  localparam logic [stateWidth-1:0] stExecute = 2'd1;
  localparam logic [stateWidth-1:0] stWriteback = 2'd2;
  localparam logic [stateWidth-1:0] stCompare = 2'd3;

  // Next-address selection
  localparam logic [nextSelWidth-1:0] nextHold = 2'd0;
  localparam logic [nextSelWidth-1:0] nextDecode = 2'd1;
  localparam logic [nextSelWidth-1:0] nextIdle = 2'd2;

  typedef struct packed {
    logic latchInstr;
    logic captureResult;
    logic writeReg;
    logic alwaysFlags;
    logic maySetFlags;
    logic doneOut;
    logic [nextSelWidth-1:0] nextSel;
  } ctrlWordT;

endpackage

`default_nettype wire

/* alu/alu.sv */
`default_nettype none

module alu
(
  input  logic [isaPkg::dataWidth-1:0] opA,
  input  logic [isaPkg::dataWidth-1:0] opB,
  input  isaPkg::opcodeT opcode,
  input  logic carryIn,
  output logic [isaPkg::dataWidth-1:0] result,
  output isaPkg::flagsT flagsOut
);

  localparam int msb = isaPkg::dataWidth - 1;

  logic arith;
  logic subtract;
  logic reverse;
  logic useCarry;
  logic addCin;
  logic [msb:0] addX;
  logic [msb:0] addYRaw;
  logic [msb:0] addY;
  logic [msb+1:0] sum;
  logic [msb:0] logicRes;

  assign arith = opcode inside {isaPkg::opSub, isaPkg::opRsb, isaPkg::opAdd, isaPkg::opAdc,
                                isaPkg::opSbc, isaPkg::opRsc, isaPkg::opCmp, isaPkg::opCmn};
  assign subtract = opcode inside {isaPkg::opSub, isaPkg::opRsb, isaPkg::opSbc,
                                   isaPkg::opRsc, isaPkg::opCmp};
  assign reverse = opcode inside {isaPkg::opRsb, isaPkg::opRsc};
  assign useCarry = opcode inside {isaPkg::opAdc, isaPkg::opSbc, isaPkg::opRsc};

  // Subtraction as x + ~y + 1, so carry out is not-borrow
  assign addX = reverse ? opB : opA;
  assign addYRaw = reverse ? opA : opB;
  assign addY = subtract ? ~addYRaw : addYRaw;
  assign addCin = useCarry ? carryIn : subtract;
  assign sum = {1'b0, addX} + {1'b0, addY} + {{isaPkg::dataWidth{1'b0}}, addCin};

  always_comb
  begin
    case (opcode)
      isaPkg::opAnd, isaPkg::opTst: logicRes = opA & opB;
      isaPkg::opEor, isaPkg::opTeq: logicRes = opA ^ opB;
      isaPkg::opOrr: logicRes = opA | opB;
      isaPkg::opMov: logicRes = opB;
      isaPkg::opBic: logicRes = opA & ~opB;
      isaPkg::opMvn: logicRes = ~opB;
      default: logicRes = '0;
    endcase
  end

  assign result = arith ? sum[msb:0] : logicRes;

  assign flagsOut.n = result[msb];
  assign flagsOut.z = (result == '0);
  // Logic ops pass the old carry through
  assign flagsOut.c = arith ? sum[msb+1] : carryIn;
  // Same-sign inputs giving a different-sign sum
  assign flagsOut.v = arith & (addX[msb] == addY[msb]) & (sum[msb] != addX[msb]);

endmodule

`default_nettype wire

/* alu/executeUnit.sv */
`default_nettype none

module executeUnit
(
  input  logic clk,
  input  logic reset,
  input  logic [isaPkg::dataWidth-1:0] instr,
  input  logic latchInstr,
  input  logic captureResult,
  input  logic flagsEn,
  input  logic [isaPkg::dataWidth-1:0] rnData,
  input  logic [isaPkg::dataWidth-1:0] rmData,
  output logic [isaPkg::regAddrWidth-1:0] rnAddr,
  output logic [isaPkg::regAddrWidth-1:0] rmAddr,
  output logic [isaPkg::regAddrWidth-1:0] rdAddr,
  output logic isTestOp,
  output logic setFlags,
  output logic [isaPkg::dataWidth-1:0] result,
  output isaPkg::flagsT flags
);

  isaPkg::instrT instrReg;
  isaPkg::flagsT aluFlags;
  isaPkg::flagsT pendingFlags;
  logic [isaPkg::dataWidth-1:0] operand2;
  logic [isaPkg::dataWidth-1:0] aluResult;

  always_ff @(posedge clk)
  begin
    if (latchInstr)
      instrReg <= instr;
  end

  assign rnAddr = instrReg.regForm.rn;
  assign rmAddr = instrReg.regForm.rm;
  assign rdAddr = instrReg.regForm.rd;
  assign setFlags = instrReg.regForm.setFlags;
  // TST, TEQ, CMP, CMN
  assign isTestOp = (instrReg.regForm.opcode[3:2] == 2'b10);

  // Zero-extended imm8 or Rm
  assign operand2 = instrReg.regForm.immFlag
                  ? {{(isaPkg::dataWidth - 8){1'b0}}, instrReg.immForm.imm8}
                  : rmData;

  alu u_alu
  (
    .opA      (rnData),
    .opB      (operand2),
    .opcode   (instrReg.regForm.opcode),
    .carryIn  (flags.c),
    .result   (aluResult),
    .flagsOut (aluFlags)
  );

  always_ff @(posedge clk)
  begin
    if (reset)
      result <= '0;
    else if (captureResult)
      result <= aluResult;
  end

  always_ff @(posedge clk)
  begin
    if (captureResult)
      pendingFlags <= aluFlags;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      flags <= '0;
    else if (flagsEn)
      flags <= pendingFlags;
  end

  // Sequencer must give the instruction register a cycle to settle
  noCaptureOnLatch: assert property (@(posedge clk) disable iff (reset)
    !(captureResult && latchInstr));

endmodule

`default_nettype wire

/* control/controlRom.sv */
`default_nettype none

module controlRom
(
  input  logic [corePkg::stateWidth-1:0] state,
  output corePkg::ctrlWordT ctrl
);

  always_comb
  begin
    ctrl = '0;
    case (state)
      corePkg::stIdle:
      begin
        ctrl.latchInstr = 1'b1;
        ctrl.nextSel = corePkg::nextHold;
      end
      corePkg::stExecute:
      begin
        ctrl.captureResult = 1'b1;
        ctrl.nextSel = corePkg::nextDecode;
      end
      corePkg::stWriteback:
      begin
        ctrl.writeReg = 1'b1;
        ctrl.maySetFlags = 1'b1;
        ctrl.doneOut = 1'b1;
        ctrl.nextSel = corePkg::nextIdle;
      end
      // Flags only, destination untouched
      corePkg::stCompare:
      begin
        ctrl.alwaysFlags = 1'b1;
        ctrl.doneOut = 1'b1;
        ctrl.nextSel = corePkg::nextIdle;
      end
      default:
      begin
        ctrl.nextSel = corePkg::nextIdle;
      end
    endcase
  end

endmodule

`default_nettype wire

/* control/microSequencer.sv */
`default_nettype none

module microSequencer
(
  input  logic clk,
  input  logic reset,
  input  logic instrValid,
  input  logic isTestOp,
  input  logic setFlags,
  output logic latchInstr,
  output logic captureResult,
  output logic regWriteEn,
  output logic flagsEn,
  output logic done
);

  logic [corePkg::stateWidth-1:0] state;
  logic [corePkg::stateWidth-1:0] nextState;
  logic [corePkg::stateWidth-1:0] decodedState;
  corePkg::ctrlWordT ctrl;

  controlRom u_controlRom
  (
    .state (state),
    .ctrl  (ctrl)
  );

  // Class encoder
  assign decodedState = isTestOp ? corePkg::stCompare : corePkg::stWriteback;

  always_comb
  begin
    case (ctrl.nextSel)
      // Wait in place, step forward on a strobe
      corePkg::nextHold: nextState = instrValid ? state + 1'b1 : state;
      corePkg::nextDecode: nextState = decodedState;
      default: nextState = corePkg::stIdle;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= corePkg::stIdle;
      done <= 1'b0;
    end
    else
    begin
      state <= nextState;
      done <= ctrl.doneOut;
    end
  end

  assign latchInstr = ctrl.latchInstr & instrValid;
  assign captureResult = ctrl.captureResult;
  assign regWriteEn = ctrl.writeReg;
  assign flagsEn = ctrl.alwaysFlags | (ctrl.maySetFlags & setFlags);

  doneSinglePulse: assert property (@(posedge clk) disable iff (reset) done |=> !done);

  noWriteOnCompare: assert property (@(posedge clk) disable iff (reset)
    !(regWriteEn && state == corePkg::stCompare));

endmodule

`default_nettype wire

/* hdl/registerFile.sv */
`default_nettype none

module registerFile
(
  input  logic clk,
  input  logic reset,
  input  logic writeEn,
  input  logic [isaPkg::regAddrWidth-1:0] writeAddr,
  input  logic [isaPkg::regAddrWidth-1:0] readAddrA,
  input  logic [isaPkg::regAddrWidth-1:0] readAddrB,
  input  logic [isaPkg::dataWidth-1:0] writeData,
  output logic [isaPkg::dataWidth-1:0] readDataA,
  output logic [isaPkg::dataWidth-1:0] readDataB
);

  logic [isaPkg::dataWidth-1:0] regs [isaPkg::numRegs];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < isaPkg::numRegs; i++)
        regs[i] <= '0;
    end
    else if (writeEn)
      regs[writeAddr] <= writeData;
  end

  // Asynchronous read ports
  assign readDataA = regs[readAddrA];
  assign readDataB = regs[readAddrB];

endmodule

`default_nettype wire

/* hdl/armCore.sv */
`default_nettype none

module armCore
(
  input  logic clk,
  input  logic reset,
  input  logic instrValid,
  input  logic [isaPkg::dataWidth-1:0] instr,
  output logic done,
  output logic [isaPkg::dataWidth-1:0] result,
  output isaPkg::flagsT flags
);

  logic latchInstr;
  logic captureResult;
  logic regWriteEn;
  logic flagsEn;
  logic isTestOp;
  logic setFlags;
  logic [isaPkg::regAddrWidth-1:0] rnAddr;
  logic [isaPkg::regAddrWidth-1:0] rmAddr;
  logic [isaPkg::regAddrWidth-1:0] rdAddr;
  logic [isaPkg::dataWidth-1:0] rnData;
  logic [isaPkg::dataWidth-1:0] rmData;

  registerFile u_registerFile
  (
    .clk       (clk),
    .reset     (reset),
    .writeEn   (regWriteEn),
    .writeAddr (rdAddr),
    .readAddrA (rnAddr),
    .readAddrB (rmAddr),
    .writeData (result),
    .readDataA (rnData),
    .readDataB (rmData)
  );

  executeUnit u_executeUnit
  (
    .clk           (clk),
    .reset         (reset),
    .instr         (instr),
    .latchInstr    (latchInstr),
    .captureResult (captureResult),
    .flagsEn       (flagsEn),
    .rnData        (rnData),
    .rmData        (rmData),
    .rnAddr        (rnAddr),
    .rmAddr        (rmAddr),
    .rdAddr        (rdAddr),
    .isTestOp      (isTestOp),
    .setFlags      (setFlags),
    .result        (result),
    .flags         (flags)
  );

  microSequencer u_microSequencer
  (
    .clk           (clk),
    .reset         (reset),
    .instrValid    (instrValid),
    .isTestOp      (isTestOp),
    .setFlags      (setFlags),
    .latchInstr    (latchInstr),
    .captureResult (captureResult),
    .regWriteEn    (regWriteEn),
    .flagsEn       (flagsEn),
    .done          (done)
  );

endmodule

`default_nettype wire

/* test/tbArmCore.sv */
`default_nettype none

module tbArmCore;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int clkPeriod = 20;
  localparam int driveDelay = 2;
  localparam int latency = 3;
  localparam int doneTimeout = 10;
  // About 230 instructions over all tests, 4 cycles each
  localparam int instrCount = 240;
  localparam int watchdogNs = (8 + instrCount * 4 + 100) * clkPeriod;

  logic clk;
  logic reset;
  logic instrValid;
  logic [isaPkg::dataWidth-1:0] instr;
  logic done;
  logic [isaPkg::dataWidth-1:0] result;
  isaPkg::flagsT flags;

  logic [31:0] shadowRegs [16];
  isaPkg::flagsT shadowFlags;
  logic [31:0] lastResult;
  int seed;
  int errorCount;
  int checkCount;
  int testCount;

  armCore u_armCore
  (
    .clk        (clk),
    .reset      (reset),
    .instrValid (instrValid),
    .instr      (instr),
    .done       (done),
    .result     (result),
    .flags      (flags)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  initial
  begin
    #(watchdogNs);
    $display("Watchdog expired before the tests finished");
    $display("STATUS: FAIL");
    $finish;
  end

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic reportTest(input string name, input int startErrors);
    testCount++;
    if (errorCount == startErrors)
      $display("%s: ok", name);
    else
      $display("%s: %0d errors", name, errorCount - startErrors);
  endtask

  function automatic logic [31:0] encodeInstr(input logic [3:0] op, input logic s,
                                              input logic imm, input logic [3:0] rd,
                                              input logic [3:0] rn, input logic [7:0] op2);
    isaPkg::instrT w;
    w = '0;
    w.immForm.cond = 4'hE;
    w.immForm.immFlag = imm;
    w.immForm.opcode = isaPkg::opcodeT'(op);
    w.immForm.setFlags = s;
    w.immForm.rn = rn;
    w.immForm.rd = rd;
    if (imm)
      w.immForm.imm8 = op2;
    else
      w.regForm.rm = op2[3:0];
    return w;
  endfunction

  // Reference behavior of the sixteen data-processing operations
  task automatic modelAlu(input logic [3:0] op, input logic [31:0] a, input logic [31:0] b,
                          input logic cin, output logic [31:0] res, output isaPkg::flagsT f);
    logic [32:0] wide;
    case (op)
      isaPkg::opAdd, isaPkg::opCmn: wide = {1'b0, a} + {1'b0, b};
      isaPkg::opAdc: wide = {1'b0, a} + {1'b0, b} + {32'b0, cin};
      isaPkg::opSub, isaPkg::opCmp: wide = {1'b0, a} - {1'b0, b};
      isaPkg::opSbc: wide = {1'b0, a} - {1'b0, b} - {32'b0, ~cin};
      isaPkg::opRsb: wide = {1'b0, b} - {1'b0, a};
      isaPkg::opRsc: wide = {1'b0, b} - {1'b0, a} - {32'b0, ~cin};
      isaPkg::opAnd, isaPkg::opTst: wide = {cin, a & b};
      isaPkg::opEor, isaPkg::opTeq: wide = {cin, a ^ b};
      isaPkg::opOrr: wide = {cin, a | b};
      isaPkg::opMov: wide = {cin, b};
      isaPkg::opBic: wide = {cin, a & ~b};
      default: wide = {cin, ~b};
    endcase
    res = wide[31:0];
    f.n = res[31];
    f.z = (res == '0);
    f.c = wide[32];
    f.v = 1'b0;
    case (op)
      isaPkg::opAdd, isaPkg::opAdc, isaPkg::opCmn:
        f.v = (a[31] == b[31]) && (res[31] != a[31]);
      // Borrow out of the 33-bit difference is the inverted carry
      isaPkg::opSub, isaPkg::opSbc, isaPkg::opCmp:
      begin
        f.c = ~wide[32];
        f.v = (a[31] != b[31]) && (res[31] != a[31]);
      end
      isaPkg::opRsb, isaPkg::opRsc:
      begin
        f.c = ~wide[32];
        f.v = (a[31] != b[31]) && (res[31] != b[31]);
      end
      default:
      begin
      end
    endcase
  endtask

  // Issue one instruction, wait for done, check it and update the shadow state
  task automatic runInstr(input logic [31:0] word);
    isaPkg::instrT w;
    logic [31:0] opB;
    logic [31:0] expRes;
    isaPkg::flagsT expFlags;
    logic compareOp;
    int edges;
    w = word;
    compareOp = w.regForm.opcode inside {isaPkg::opTst, isaPkg::opTeq,
                                         isaPkg::opCmp, isaPkg::opCmn};
    opB = w.regForm.immFlag ? {24'b0, w.immForm.imm8} : shadowRegs[w.regForm.rm];
    modelAlu(w.regForm.opcode, shadowRegs[w.regForm.rn], opB, shadowFlags.c, expRes, expFlags);
    instr = word;
    instrValid = 1'b1;
    @(posedge clk);
    #driveDelay;
    instrValid = 1'b0;
    edges = 1;
    while (!done && edges < doneTimeout)
    begin
      @(posedge clk);
      #driveDelay;
      edges++;
    end
    if (!done)
    begin
      errorCount++;
      $display("No done pulse within %0d cycles for instruction %h", doneTimeout, word);
    end
    else
      checkValue("latency", 32'(edges), 32'(latency));
    if (!compareOp)
      shadowRegs[w.regForm.rd] = expRes;
    if (compareOp || w.regForm.setFlags)
      shadowFlags = expFlags;
    lastResult = expRes;
    checkValue("result", result, expRes);
    checkValue("flags", 32'(flags), 32'(shadowFlags));
  endtask

  // Build a full word from bytes with MOV, doubling ADDs and ORR
  task automatic loadWord(input logic [3:0] rd, input logic [31:0] value);
    runInstr(encodeInstr(isaPkg::opMov, 1'b0, 1'b1, rd, 4'd0, value[31:24]));
    for (int b = 2; b >= 0; b--)
    begin
      repeat (8)
        runInstr(encodeInstr(isaPkg::opAdd, 1'b0, 1'b0, rd, rd, {4'd0, rd}));
      runInstr(encodeInstr(isaPkg::opOrr, 1'b0, 1'b1, rd, rd, value[b*8 +: 8]));
    end
    checkValue("loaded word", result, value);
  endtask

  task automatic testLoadRegisters();
    int start;
    logic [7:0] values [16];
    start = errorCount;
    checkValue("result", result, '0);
    checkValue("flags", 32'(flags), '0);
    runInstr(encodeInstr(isaPkg::opMov, 1'b1, 1'b0, 4'd0, 4'd0, 8'd15));
    for (int i = 0; i < 16; i++)
    begin
      values[i] = 8'($random(seed));
      runInstr(encodeInstr(isaPkg::opMov, 1'(i), 1'b1, 4'(i), 4'd0, values[i]));
    end
    for (int i = 0; i < 16; i++)
    begin
      runInstr(encodeInstr(isaPkg::opMov, 1'b1, 1'b0, 4'(i), 4'd0, 8'(i)));
      checkValue("readback", result, {24'b0, values[i]});
    end
    reportTest("register load and readback", start);
  endtask

  task automatic testRandomOps();
    int start;
    logic [31:0] expected;
    start = errorCount;
    for (int round = 0; round < 2; round++)
    begin
      loadWord(4'd1, $random(seed));
      loadWord(4'd2, $random(seed));
      for (int op = 0; op < 16; op++)
      begin
        if (op >= 8 && op < 12)
          continue;
        runInstr(encodeInstr(4'(op), 1'b1, 1'(round), 4'd3, 4'd1,
                             round == 1 ? 8'($random(seed)) : 8'd2));
        expected = lastResult;
        runInstr(encodeInstr(isaPkg::opMov, 1'b0, 1'b0, 4'd9, 4'd0, 8'd3));
        checkValue("r3", result, expected);
      end
    end
    reportTest("random operations", start);
  endtask

  task automatic testCarryOps();
    int start;
    start = errorCount;
    runInstr(encodeInstr(isaPkg::opMov, 1'b0, 1'b1, 4'd5, 4'd0, 8'd1));
    for (int op = isaPkg::opAdc; op <= isaPkg::opRsc; op++)
    begin
      for (int carry = 0; carry < 2; carry++)
      begin
        // 1 - 0 leaves carry set, 1 - 2 borrows
        runInstr(encodeInstr(isaPkg::opCmp, 1'b1, 1'b1, 4'd0, 4'd5,
                             carry == 1 ? 8'd0 : 8'd2));
        checkValue("flags.c", 32'(flags.c), 32'(carry));
        runInstr(encodeInstr(4'(op), 1'b1, 1'b0, 4'd4, 4'd1, 8'd2));
      end
    end
    reportTest("carry-in operations", start);
  endtask

  task automatic testCompareOps();
    int start;
    start = errorCount;
    runInstr(encodeInstr(isaPkg::opMov, 1'b0, 1'b1, 4'd6, 4'd0, 8'hA5));
    for (int op = isaPkg::opTst; op <= isaPkg::opCmn; op++)
    begin
      runInstr(encodeInstr(4'(op), 1'b1, 1'b0, 4'd6, 4'd1, 8'd2));
      runInstr(encodeInstr(isaPkg::opMov, 1'b0, 1'b0, 4'd7, 4'd0, 8'd6));
      checkValue("r6", result, 32'hA5);
    end
    reportTest("test and compare operations", start);
  endtask

  task automatic testFlagsHold();
    int start;
    isaPkg::flagsT saved;
    start = errorCount;
    runInstr(encodeInstr(isaPkg::opMov, 1'b0, 1'b1, 4'd5, 4'd0, 8'd1));
    runInstr(encodeInstr(isaPkg::opCmp, 1'b1, 1'b1, 4'd0, 4'd5, 8'd2));
    saved = shadowFlags;
    runInstr(encodeInstr(isaPkg::opAdd, 1'b0, 1'b0, 4'd10, 4'd1, 8'd2));
    checkValue("flags", 32'(flags), 32'(saved));
    runInstr(encodeInstr(isaPkg::opMov, 1'b0, 1'b1, 4'd10, 4'd0, 8'd0));
    checkValue("flags", 32'(flags), 32'(saved));
    runInstr(encodeInstr(isaPkg::opSub, 1'b0, 1'b1, 4'd10, 4'd5, 8'd1));
    checkValue("flags", 32'(flags), 32'(saved));
    reportTest("flags held with S clear", start);
  endtask

  task automatic testBusyStrobe();
    int start;
    int pulses;
    int doneEdge;
    start = errorCount;
    instr = encodeInstr(isaPkg::opMov, 1'b0, 1'b1, 4'd8, 4'd0, 8'h55);
    instrValid = 1'b1;
    @(posedge clk);
    #driveDelay;
    // Second strobe lands while the first is executing
    instr = encodeInstr(isaPkg::opMov, 1'b0, 1'b1, 4'd8, 4'd0, 8'hAA);
    @(posedge clk);
    #driveDelay;
    instrValid = 1'b0;
    pulses = done ? 1 : 0;
    doneEdge = 0;
    for (int e = 3; e <= 10; e++)
    begin
      @(posedge clk);
      #driveDelay;
      if (done)
      begin
        pulses++;
        doneEdge = e;
      end
    end
    checkValue("done pulses", 32'(pulses), 32'd1);
    checkValue("done edge", 32'(doneEdge), 32'(latency));
    checkValue("result", result, 32'h55);
    shadowRegs[8] = 32'h55;
    runInstr(encodeInstr(isaPkg::opMov, 1'b0, 1'b0, 4'd11, 4'd0, 8'd8));
    checkValue("r8", result, 32'h55);
    reportTest("strobe while busy", start);
  endtask

  initial
  begin
    seed = 27;
    errorCount = 0;
    checkCount = 0;
    testCount = 0;
    reset = 1'b1;
    instrValid = 1'b0;
    instr = '0;
    shadowFlags = '0;
    lastResult = '0;
    for (int i = 0; i < 16; i++)
      shadowRegs[i] = '0;
    repeat (8) @(posedge clk);
    #driveDelay;
    reset = 1'b0;

    testLoadRegisters();
    testRandomOps();
    testCarryOps();
    testCompareOps();
    testFlagsHold();
    testBusyStrobe();

    $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
    if (errorCount == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* armCore.f */
common/isaPkg.sv
common/corePkg.sv
alu/alu.sv
alu/executeUnit.sv
control/controlRom.sv
control/microSequencer.sv
hdl/registerFile.sv
hdl/armCore.sv
test/tbArmCore.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the armCore testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tbArmCore -f armCore.f -o simArmCore \
  && ./obj_dir/simArmCore | tee sim.log \
  && grep -q "^STATUS: PASS$" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
